//--- src/cpu_isa_pkg.sv
`default_nettype none

package cpu_isa_pkg;

    // word and field widths
    localparam int WORD  = 32;
    localparam int W_OPR = 32;
    localparam int ADDR  = 16;
    localparam int W_RD  = 4;
    localparam int W_IMM = 20;
    localparam int W_OP  = 4;

    // opcodes, 0 must stay NOP so an all-zero word is a bubble
    localparam logic [W_OP-1:0] OP_NOP  = 4'h0;
    localparam logic [W_OP-1:0] OP_ADD  = 4'h1;
    localparam logic [W_OP-1:0] OP_SUB  = 4'h2;
    localparam logic [W_OP-1:0] OP_AND  = 4'h3;
    localparam logic [W_OP-1:0] OP_OR   = 4'h4;
    localparam logic [W_OP-1:0] OP_XOR  = 4'h5;
    localparam logic [W_OP-1:0] OP_SLT  = 4'h6;
    localparam logic [W_OP-1:0] OP_ADDI = 4'h7;
    localparam logic [W_OP-1:0] OP_LD   = 4'h8;
    localparam logic [W_OP-1:0] OP_ST   = 4'h9;
    localparam logic [W_OP-1:0] OP_BEQ  = 4'ha;
    localparam logic [W_OP-1:0] OP_BNE  = 4'hb;
    localparam logic [W_OP-1:0] OP_JMP  = 4'hc;
    localparam logic [W_OP-1:0] OP_HLT  = 4'hf;

    // rd = rs op rt
    typedef struct packed {
        logic [W_OP-1:0]                op;
        logic [W_RD-1:0]                rd;
        logic [W_RD-1:0]                rs;
        logic [W_RD-1:0]                rt;
        logic [WORD-W_OP-3*W_RD-1:0]    unused;
    } r_form_t;

    // addi, ld, st, branches and jmp
    typedef struct packed {
        logic [W_OP-1:0]  op;
        logic [W_RD-1:0]  rd;
        logic [W_RD-1:0]  rs;
        logic [W_IMM-1:0] imm;
    } i_form_t;

    typedef union packed {
        r_form_t r;
        i_form_t i;
    } instr_u;

endpackage

`default_nettype wire

//--- src/cpu_pipe_pkg.sv
`default_nettype none

package cpu_pipe_pkg;

    import cpu_isa_pkg::*;

    // alu select
    localparam int W_ALU = 3;

    localparam logic [W_ALU-1:0] ALU_ADD = 3'd0;
    localparam logic [W_ALU-1:0] ALU_SUB = 3'd1;
    localparam logic [W_ALU-1:0] ALU_AND = 3'd2;
    localparam logic [W_ALU-1:0] ALU_OR  = 3'd3;
    localparam logic [W_ALU-1:0] ALU_XOR = 3'd4;
    localparam logic [W_ALU-1:0] ALU_SLT = 3'd5;

    // first fetch address
    localparam logic [ADDR-1:0] RESET_PC = '0;

    // decodes as OP_NOP
    localparam logic [WORD-1:0] BUBBLE_WORD = '0;

endpackage

`default_nettype wire

//--- src/fetch_stage.sv
`default_nettype none

module fetch_stage
    import cpu_isa_pkg::*;
    import cpu_pipe_pkg::*;
(
    input  wire              clk,
    input  wire              rst_n_i,
    input  wire              stall_i,
    input  wire              redirect_i,
    input  wire [ADDR-1:0]   redirect_pc_i,
    input  wire              halted_i,
    input  wire [WORD-1:0]   inst_i,
    output logic [ADDR-1:0]  inst_addr_o,
    output logic             valid_o,
    output logic [WORD-1:0]  inst_o,
    output logic [ADDR-1:0]  pc_o
);

    logic [ADDR-1:0] pc_q;
    logic            advance;

    // target goes out in the cycle execute resolves it
    assign inst_addr_o = redirect_i ? redirect_pc_i : pc_q;

    assign advance = !stall_i && !halted_i;

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            pc_q    <= RESET_PC;
            valid_o <= 1'b0;
        end else if (redirect_i) begin
            // refetch the target next cycle
            pc_q    <= redirect_pc_i;
            valid_o <= 1'b0;
        end else if (advance) begin
            pc_q    <= pc_q + 1'b1;
            valid_o <= 1'b1;
        end
    end

    // fetch latch payload
    always_ff @(posedge clk) begin
        if (redirect_i) begin
            inst_o <= BUBBLE_WORD;
            pc_o   <= redirect_pc_i;
        end else if (advance) begin
            inst_o <= inst_i;
            pc_o   <= pc_q;
        end
    end

endmodule

`default_nettype wire

//--- src/decode_stage.sv
`default_nettype none

module decode_stage
    import cpu_isa_pkg::*;
    import cpu_pipe_pkg::*;
(
    input  wire               clk,
    input  wire               rst_n_i,
    input  wire               valid_i,
    input  wire [WORD-1:0]    inst_i,
    input  wire [ADDR-1:0]    pc_i,
    input  wire               flush_i,
    input  wire               hold_i,
    input  wire               halted_i,
    output logic [W_RD-1:0]   rd_addr0_o,
    output logic [W_RD-1:0]   rd_addr1_o,
    input  wire [W_OPR-1:0]   rd_data0_i,
    input  wire [W_OPR-1:0]   rd_data1_i,
    input  wire               src_reserved_i,
    output logic              reserve_en_o,
    output logic [W_RD-1:0]   reserve_reg_o,
    output logic              stall_o,
    output logic              valid_o,
    output logic [ADDR-1:0]   pc_o,
    output logic [W_OPR-1:0]  opr0_o,
    output logic [W_OPR-1:0]  opr1_o,
    output logic [W_OPR-1:0]  imm_o,
    output logic [W_OP-1:0]   op_o,
    output logic [W_ALU-1:0]  alu_o,
    output logic              wb_o,
    output logic [W_RD-1:0]   rd_o
);

    instr_u           word;
    logic             is_reg_form;
    logic             writes_rd;
    logic             wb_needed;
    logic             issue;
    logic [W_ALU-1:0] alu_sel;
    logic [W_OPR-1:0] imm_ext;

    assign word = inst_i;

    // operand 0 is always rs, operand 1 is rt or rd
    always_comb begin
        is_reg_form = 1'b0;
        writes_rd   = 1'b0;
        rd_addr0_o  = '0;
        rd_addr1_o  = '0;
        case (word.r.op)
            OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR, OP_SLT: begin
                is_reg_form = 1'b1;
                writes_rd   = 1'b1;
                rd_addr0_o  = word.r.rs;
                rd_addr1_o  = word.r.rt;
            end
            OP_ADDI, OP_LD: begin
                writes_rd  = 1'b1;
                rd_addr0_o = word.i.rs;
            end
            OP_ST, OP_BEQ, OP_BNE: begin
                rd_addr0_o = word.i.rs;
                rd_addr1_o = word.i.rd;
            end
            default: ;
        endcase
    end

    always_comb begin
        case (word.r.op)
            OP_SUB:  alu_sel = ALU_SUB;
            OP_AND:  alu_sel = ALU_AND;
            OP_OR:   alu_sel = ALU_OR;
            OP_XOR:  alu_sel = ALU_XOR;
            OP_SLT:  alu_sel = ALU_SLT;
            default: alu_sel = ALU_ADD;
        endcase
    end

    assign imm_ext = is_reg_form ? '0 : {{(W_OPR-W_IMM){word.i.imm[W_IMM-1]}}, word.i.imm};

    // writes to r0 are dropped, so they need no reservation
    assign wb_needed = writes_rd && (word.r.rd != '0);

    assign issue   = valid_i && !src_reserved_i && !hold_i && !flush_i && !halted_i;
    assign stall_o = hold_i || (valid_i && src_reserved_i);

    assign reserve_en_o  = issue && wb_needed;
    assign reserve_reg_o = word.r.rd;

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            valid_o <= 1'b0;
        end else if (!hold_i) begin
            valid_o <= issue;
        end
    end

    // issue register payload
    always_ff @(posedge clk) begin
        if (issue) begin
            pc_o   <= pc_i;
            opr0_o <= rd_data0_i;
            opr1_o <= rd_data1_i;
            imm_o  <= imm_ext;
            op_o   <= word.r.op;
            alu_o  <= alu_sel;
            wb_o   <= wb_needed;
            rd_o   <= word.r.rd;
        end
    end

endmodule

`default_nettype wire

//--- src/reg_file.sv
`default_nettype none

module reg_file
    import cpu_isa_pkg::*;
(
    input  wire              clk,
    input  wire              rst_n_i,
    input  wire [W_RD-1:0]   rd_addr0_i,
    input  wire [W_RD-1:0]   rd_addr1_i,
    output logic [W_OPR-1:0] rd_data0_o,
    output logic [W_OPR-1:0] rd_data1_o,
    output logic             src_reserved_o,
    input  wire              reserve_en_i,
    input  wire [W_RD-1:0]   reserve_reg_i,
    input  wire              wb_en_i,
    input  wire [W_RD-1:0]   wb_reg_i,
    input  wire [W_OPR-1:0]  wb_data_i
);

    logic [W_OPR-1:0]   regs [2**W_RD];
    logic [2**W_RD-1:0] rsv_q;

    assign rd_data0_o = (rd_addr0_i == '0) ? '0 : regs[rd_addr0_i];
    assign rd_data1_o = (rd_addr1_i == '0) ? '0 : regs[rd_addr1_i];

    // bit 0 is never set
    assign src_reserved_o = rsv_q[rd_addr0_i] | rsv_q[rd_addr1_i];

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            for (int i = 0; i < 2**W_RD; i++) begin
                regs[i] <= '0;
            end
        end else if (wb_en_i && (wb_reg_i != '0)) begin
            regs[wb_reg_i] <= wb_data_i;
        end
    end

    // scoreboard
    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            rsv_q <= '0;
        end else begin
            if (wb_en_i) begin
                rsv_q[wb_reg_i] <= 1'b0;
            end
            // a new reservation wins over a same-edge writeback
            if (reserve_en_i && (reserve_reg_i != '0)) begin
                rsv_q[reserve_reg_i] <= 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

//--- src/execute_stage.sv
`default_nettype none

module execute_stage
    import cpu_isa_pkg::*;
    import cpu_pipe_pkg::*;
(
    input  wire               clk,
    input  wire               rst_n_i,
    input  wire               stall_i,
    input  wire               valid_i,
    input  wire [ADDR-1:0]    pc_i,
    input  wire [W_OPR-1:0]   opr0_i,
    input  wire [W_OPR-1:0]   opr1_i,
    input  wire [W_OPR-1:0]   imm_i,
    input  wire [W_OP-1:0]    op_i,
    input  wire [W_ALU-1:0]   alu_i,
    input  wire               wb_i,
    input  wire [W_RD-1:0]    rd_i,
    output logic              hold_o,
    output logic              redirect_o,
    output logic [ADDR-1:0]   redirect_pc_o,
    output logic              wb_en_o,
    output logic [W_RD-1:0]   wb_reg_o,
    output logic [W_OPR-1:0]  wb_data_o,
    output logic [ADDR-1:0]   ldst_addr_o,
    output logic [W_OPR-1:0]  ldst_data_o,
    output logic              ldst_write_o,
    input  wire [W_OPR-1:0]   ldst_data_i,
    output logic              halted_o
);

    logic             halted_q;
    logic             active;
    logic             use_imm;
    logic             taken;
    logic [W_OPR-1:0] opb;
    logic [W_OPR-1:0] alu_res;

    // no effect at all unless this is true
    assign active = valid_i && !stall_i && !halted_q;

    // external stall freezes the issue register too
    assign hold_o = stall_i;

    assign use_imm = (op_i == OP_ADDI) || (op_i == OP_LD) || (op_i == OP_ST);
    assign opb     = use_imm ? imm_i : opr1_i;

    always_comb begin
        case (alu_i)
            ALU_ADD: alu_res = opr0_i + opb;
            ALU_SUB: alu_res = opr0_i - opb;
            ALU_AND: alu_res = opr0_i & opb;
            ALU_OR:  alu_res = opr0_i | opb;
            ALU_XOR: alu_res = opr0_i ^ opb;
            ALU_SLT: alu_res = {{(W_OPR-1){1'b0}}, $signed(opr0_i) < $signed(opb)};
            default: alu_res = '0;
        endcase
    end

    // branches compare rd with rs
    always_comb begin
        case (op_i)
            OP_BEQ:  taken = (opr0_i == opr1_i);
            OP_BNE:  taken = (opr0_i != opr1_i);
            OP_JMP:  taken = 1'b1;
            default: taken = 1'b0;
        endcase
    end

    assign redirect_o    = active && taken;
    assign redirect_pc_o = pc_i + imm_i[ADDR-1:0];

    // word address is the low bits of rs + imm
    assign ldst_addr_o  = alu_res[ADDR-1:0];
    assign ldst_data_o  = opr1_i;
    assign ldst_write_o = active && (op_i == OP_ST);

    assign wb_en_o   = active && wb_i;
    assign wb_reg_o  = rd_i;
    assign wb_data_o = (op_i == OP_LD) ? ldst_data_i : alu_res;

    // sticky until reset
    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            halted_q <= 1'b0;
        end else if (active && (op_i == OP_HLT)) begin
            halted_q <= 1'b1;
        end
    end

    assign halted_o = halted_q;

endmodule

`default_nettype wire

//--- src/cpu_top.sv
`default_nettype none

module cpu_top
    import cpu_isa_pkg::*;
    import cpu_pipe_pkg::*;
(
    input  wire              clk,
    input  wire              rst_n_i,
    input  wire              stall_i,
    input  wire [WORD-1:0]   inst_i,
    output logic [ADDR-1:0]  inst_addr_o,
    input  wire [W_OPR-1:0]  ldst_data_i,
    output logic [W_OPR-1:0] ldst_data_o,
    output logic [ADDR-1:0]  ldst_addr_o,
    output logic             ldst_write_o,
    output logic             hlt_o
);

    // fetch - decode
    logic             fd_valid;
    logic [WORD-1:0]  fd_inst;
    logic [ADDR-1:0]  fd_pc;
    logic             fd_stall;

    // decode - register file
    logic [W_RD-1:0]  rd_addr0;
    logic [W_RD-1:0]  rd_addr1;
    logic [W_OPR-1:0] rd_data0;
    logic [W_OPR-1:0] rd_data1;
    logic             src_reserved;
    logic             reserve_en;
    logic [W_RD-1:0]  reserve_reg;

    // decode - execute
    logic             de_valid;
    logic [ADDR-1:0]  de_pc;
    logic [W_OPR-1:0] de_opr0;
    logic [W_OPR-1:0] de_opr1;
    logic [W_OPR-1:0] de_imm;
    logic [W_OP-1:0]  de_op;
    logic [W_ALU-1:0] de_alu;
    logic             de_wb;
    logic [W_RD-1:0]  de_rd;
    logic             ex_stall;

    // execute - back to the front
    logic             wb_en;
    logic [W_RD-1:0]  wb_reg;
    logic [W_OPR-1:0] wb_data;
    logic             redirect;
    logic [ADDR-1:0]  redirect_pc;
    logic             halted;

    assign hlt_o = halted;

    fetch_stage i_fetch (
        .clk(clk), .rst_n_i(rst_n_i),
        .stall_i(fd_stall),
        .redirect_i(redirect), .redirect_pc_i(redirect_pc),
        .halted_i(halted),
        .inst_i(inst_i), .inst_addr_o(inst_addr_o),
        .valid_o(fd_valid), .inst_o(fd_inst), .pc_o(fd_pc)
    );

    decode_stage i_decode (
        .clk(clk), .rst_n_i(rst_n_i),
        .valid_i(fd_valid), .inst_i(fd_inst), .pc_i(fd_pc),
        .flush_i(redirect), .hold_i(ex_stall), .halted_i(halted),
        .rd_addr0_o(rd_addr0), .rd_addr1_o(rd_addr1),
        .rd_data0_i(rd_data0), .rd_data1_i(rd_data1),
        .src_reserved_i(src_reserved),
        .reserve_en_o(reserve_en), .reserve_reg_o(reserve_reg),
        .stall_o(fd_stall), .valid_o(de_valid), .pc_o(de_pc),
        .opr0_o(de_opr0), .opr1_o(de_opr1), .imm_o(de_imm),
        .op_o(de_op), .alu_o(de_alu), .wb_o(de_wb), .rd_o(de_rd)
    );

    reg_file i_reg_file (
        .clk(clk), .rst_n_i(rst_n_i),
        .rd_addr0_i(rd_addr0), .rd_addr1_i(rd_addr1),
        .rd_data0_o(rd_data0), .rd_data1_o(rd_data1),
        .src_reserved_o(src_reserved),
        .reserve_en_i(reserve_en), .reserve_reg_i(reserve_reg),
        .wb_en_i(wb_en), .wb_reg_i(wb_reg), .wb_data_i(wb_data)
    );

    execute_stage i_execute (
        .clk(clk), .rst_n_i(rst_n_i),
        .stall_i(stall_i), .valid_i(de_valid), .pc_i(de_pc),
        .opr0_i(de_opr0), .opr1_i(de_opr1), .imm_i(de_imm),
        .op_i(de_op), .alu_i(de_alu), .wb_i(de_wb), .rd_i(de_rd),
        .hold_o(ex_stall),
        .redirect_o(redirect), .redirect_pc_o(redirect_pc),
        .wb_en_o(wb_en), .wb_reg_o(wb_reg), .wb_data_o(wb_data),
        .ldst_addr_o(ldst_addr_o), .ldst_data_o(ldst_data_o),
        .ldst_write_o(ldst_write_o), .ldst_data_i(ldst_data_i),
        .halted_o(halted)
    );

endmodule

`default_nettype wire

//--- test/cpu_assertions.sv
`default_nettype none

module cpu_assertions
    import cpu_isa_pkg::*;
    import cpu_pipe_pkg::*;
(
    input wire            clk,
    input wire            rst_n_i,
    input wire            stall_i,
    input wire            ldst_write_o,
    input wire            hlt_o,
    input wire [ADDR-1:0] inst_addr_o
);
    timeunit 1ns;
    timeprecision 100ps;

    // stores only move while the bus is not stalled
    a_no_store_in_stall: assert property (@(posedge clk) !(ldst_write_o && stall_i))
        else $error("store strobe while stalled");

    a_halt_sticky: assert property (@(posedge clk) (hlt_o && rst_n_i) |=> (hlt_o || !rst_n_i))
        else $error("halt dropped without reset");

    a_reset_pc: assert property (@(posedge clk) $rose(rst_n_i) |-> (inst_addr_o == RESET_PC))
        else $error("first fetch not at reset pc");

endmodule

bind cpu_top cpu_assertions i_cpu_assertions (
    .clk(clk), .rst_n_i(rst_n_i), .stall_i(stall_i),
    .ldst_write_o(ldst_write_o), .hlt_o(hlt_o), .inst_addr_o(inst_addr_o)
);

`default_nettype wire

//--- test/tb_cpu_top.sv
`default_nettype none

module tb_cpu_top
    import cpu_isa_pkg::*;
    import cpu_pipe_pkg::*;
;
    timeunit 1ns;
    timeprecision 100ps;

    logic             clk;
    logic             rst_n_i;
    logic             stall_i;
    logic [WORD-1:0]  inst_i;
    logic [ADDR-1:0]  inst_addr_o;
    logic [W_OPR-1:0] ldst_data_i;
    logic [W_OPR-1:0] ldst_data_o;
    logic [ADDR-1:0]  ldst_addr_o;
    logic             ldst_write_o;
    logic             hlt_o;

    logic [WORD-1:0]  imem [64];
    logic [W_OPR-1:0] dmem [64];
    logic [ADDR-1:0]  exp_addr [256];
    logic [W_OPR-1:0] exp_data [256];
    int               exp_count;
    int               stores_seen;
    int               model_steps;
    int               load_ptr;
    logic [31:0]      lcg_state = 32'hd956ca79;
    time              deadline = 0;
    bit               timed_out = 0;

    cpu_top i_cpu_top (
        .clk(clk), .rst_n_i(rst_n_i), .stall_i(stall_i),
        .inst_i(inst_i), .inst_addr_o(inst_addr_o),
        .ldst_data_i(ldst_data_i), .ldst_data_o(ldst_data_o),
        .ldst_addr_o(ldst_addr_o), .ldst_write_o(ldst_write_o), .hlt_o(hlt_o)
    );

    // both memories answer in the same cycle
    assign inst_i      = imem[inst_addr_o[5:0]];
    assign ldst_data_i = dmem[ldst_addr_o[5:0]];

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic logic [W_OPR-1:0] fill_word(input logic [5:0] a);
        return {16'hc0de, 10'h0, a} ^ ({26'h0, a} * 32'h0100_0193);
    endfunction

    function automatic logic [WORD-1:0] reg_op_word(input logic [3:0] op, input logic [3:0] rd,
                                                    input logic [3:0] rs, input logic [3:0] rt);
        instr_u w;
        w.r = '{op: op, rd: rd, rs: rs, rt: rt, unused: '0};
        return w;
    endfunction

    function automatic logic [WORD-1:0] imm_op_word(input logic [3:0] op, input logic [3:0] rd,
                                                    input logic [3:0] rs, input logic [19:0] imm);
        instr_u w;
        w.i = '{op: op, rd: rd, rs: rs, imm: imm};
        return w;
    endfunction

    // architectural model, fills the expected store list and returns its length
    function automatic int run_model();
        logic [W_OPR-1:0] r [16];
        logic [W_OPR-1:0] m [64];
        logic [ADDR-1:0]  pc;
        logic [ADDR-1:0]  nxt;
        logic [W_OPR-1:0] a;
        logic [W_OPR-1:0] b;
        logic [W_OPR-1:0] d;
        logic [W_OPR-1:0] imm;
        logic [W_OPR-1:0] res;
        logic             wr;
        logic             done;
        instr_u           w;
        int               n;
        for (int i = 0; i < 64; i++) m[i] = fill_word(i[5:0]);
        for (int i = 0; i < 16; i++) r[i] = '0;
        pc = RESET_PC;
        n = 0;
        done = 1'b0;
        model_steps = 0;
        while (!done && model_steps < 2000) begin
            w = imem[pc[5:0]];
            a = r[w.i.rs];
            b = r[w.r.rt];
            d = r[w.i.rd];
            imm = {{(W_OPR-W_IMM){w.i.imm[W_IMM-1]}}, w.i.imm};
            nxt = pc + 16'd1;
            res = '0;
            wr = 1'b1;
            case (w.r.op)
                OP_ADD:  res = a + b;
                OP_SUB:  res = a - b;
                OP_AND:  res = a & b;
                OP_OR:   res = a | b;
                OP_XOR:  res = a ^ b;
                OP_SLT:  res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                OP_ADDI: res = a + imm;
                OP_LD:   res = m[res_addr(a, imm)];
                default: wr = 1'b0;
            endcase
            if (w.r.op == OP_ST) begin
                m[res_addr(a, imm)] = d;
                exp_addr[n] = a[ADDR-1:0] + imm[ADDR-1:0];
                exp_data[n] = d;
                n++;
            end
            if ((w.r.op == OP_BEQ && d == a) || (w.r.op == OP_BNE && d != a) || w.r.op == OP_JMP)
                nxt = pc + imm[ADDR-1:0];
            done = (w.r.op == OP_HLT);
            if (wr && w.r.rd != 4'd0) r[w.r.rd] = res;
            pc = nxt;
            model_steps++;
        end
        return n;
    endfunction

    function automatic logic [5:0] res_addr(input logic [W_OPR-1:0] a, input logic [W_OPR-1:0] i);
        logic [W_OPR-1:0] s;
        s = a + i;
        return s[5:0];
    endfunction

    task automatic check(input string name, input logic [31:0] exp, input logic [31:0] act);
        if (act !== exp) begin
            $display("ERR t=%0t %s expected %h actual %h", $time, name, exp, act);
            $display("RESULT: FAIL");
            $fatal(1);
        end
    endtask

    task automatic clear_program();
        for (int i = 0; i < 64; i++) imem[i] = BUBBLE_WORD;
        load_ptr = 0;
    endtask

    task automatic emit(input logic [WORD-1:0] w);
        imem[load_ptr] = w;
        load_ptr++;
    endtask

    // reset, run to halt, then idle to catch late stores
    task automatic run_program(input bit use_stall);
        exp_count = run_model();
        rst_n_i = 1'b0;
        stall_i = 1'b0;
        repeat (4) @(posedge clk);
        #10;
        check("inst_addr_o", {16'h0, RESET_PC}, {16'h0, inst_addr_o});
        check("ldst_write_o", 32'd0, {31'h0, ldst_write_o});
        check("hlt_o", 32'd0, {31'h0, hlt_o});
        rst_n_i = 1'b1;
        deadline = $time + (model_steps * 4 * 2 + 30) * 100;
        while (!hlt_o) begin
            @(posedge clk);
            #10;
            stall_i = use_stall ? (lcg_next() > 32'hb000_0000) : 1'b0;
        end
        stall_i = 1'b0;
        repeat (8) begin
            @(posedge clk);
            #10;
            check("hlt_o", 32'd1, {31'h0, hlt_o});
        end
        check("store count", exp_count, stores_seen);
        deadline = 0;
    endtask

    // store compare and data memory update
    always @(negedge clk) begin
        if (!rst_n_i) begin
            stores_seen <= 0;
            for (int i = 0; i < 64; i++) dmem[i] <= fill_word(i[5:0]);
        end else if (ldst_write_o) begin
            if (stores_seen >= exp_count) begin
                check("ldst_write_o", 32'd0, 32'd1);
            end
            check("ldst_addr_o", {16'h0, exp_addr[stores_seen]}, {16'h0, ldst_addr_o});
            check("ldst_data_o", exp_data[stores_seen], ldst_data_o);
            dmem[ldst_addr_o[5:0]] <= ldst_data_o;
            stores_seen <= stores_seen + 1;
        end
    end

    initial begin
        while (!timed_out) begin
            @(posedge clk);
            timed_out = (deadline != 0) && ($time > deadline);
        end
        $display("timeout: the core did not halt in the time this program allows");
        $display("RESULT: FAIL");
        $fatal(1);
    end

    task automatic build_random_program();
        logic [31:0] s;
        logic [31:0] imm_rnd;
        logic [3:0]  op;
        clear_program();
        for (int k = 0; k < 40; k++) begin
            s = lcg_next();
            case (s[31:29])
                3'd0:    op = OP_ADD;
                3'd1:    op = OP_SUB;
                3'd2:    op = OP_AND;
                3'd3:    op = OP_OR;
                3'd4:    op = OP_XOR;
                3'd5:    op = OP_SLT;
                3'd6:    op = OP_ADDI;
                default: op = s[28] ? OP_ST : OP_LD;
            endcase
            if (op == OP_ADDI) begin
                imm_rnd = lcg_next();
                emit(imm_op_word(op, {1'b0, s[27:25]}, {1'b0, s[24:22]}, imm_rnd[19:0]));
            end else if (op == OP_LD || op == OP_ST)
                emit(imm_op_word(op, {1'b0, s[27:25]}, 4'd0, {15'h0, s[4:0]}));
            else
                emit(reg_op_word(op, {1'b0, s[27:25]}, {1'b0, s[24:22]}, {1'b0, s[21:19]}));
        end
        // every result register ends up on the bus
        for (int k = 1; k < 8; k++) emit(imm_op_word(OP_ST, k[3:0], 4'd0, 20'd40 + k[19:0]));
        emit(imm_op_word(OP_HLT, 4'd0, 4'd0, 20'd0));
    endtask

    initial begin
        rst_n_i = 1'b0;
        stall_i = 1'b0;
        clear_program();
        // alu chain, r0 write, then a store behind the halt
        emit(imm_op_word(OP_ADDI, 4'd1, 4'd0, 20'd5));
        emit(imm_op_word(OP_ADDI, 4'd2, 4'd0, 20'hffffd));
        emit(reg_op_word(OP_ADD, 4'd3, 4'd1, 4'd2));
        emit(reg_op_word(OP_SUB, 4'd4, 4'd3, 4'd1));
        emit(reg_op_word(OP_AND, 4'd5, 4'd4, 4'd2));
        emit(reg_op_word(OP_OR, 4'd6, 4'd5, 4'd1));
        emit(reg_op_word(OP_XOR, 4'd7, 4'd6, 4'd2));
        emit(reg_op_word(OP_SLT, 4'd8, 4'd2, 4'd1));
        emit(reg_op_word(OP_SLT, 4'd9, 4'd1, 4'd2));
        emit(reg_op_word(OP_ADD, 4'd0, 4'd1, 4'd1));
        emit(reg_op_word(OP_ADD, 4'd10, 4'd0, 4'd1));
        for (int k = 3; k <= 10; k++) emit(imm_op_word(OP_ST, k[3:0], 4'd0, k[19:0]));
        emit(imm_op_word(OP_HLT, 4'd0, 4'd0, 20'd0));
        emit(imm_op_word(OP_ST, 4'd1, 4'd0, 20'd50));
        run_program(1'b0);

        clear_program();
        emit(imm_op_word(OP_ADDI, 4'd1, 4'd0, 20'h123));
        emit(imm_op_word(OP_ST, 4'd1, 4'd0, 20'd10));
        emit(imm_op_word(OP_LD, 4'd2, 4'd0, 20'd10));
        emit(imm_op_word(OP_ST, 4'd2, 4'd0, 20'd11));
        emit(imm_op_word(OP_LD, 4'd3, 4'd0, 20'd20));
        emit(imm_op_word(OP_ADDI, 4'd3, 4'd3, 20'd1));
        emit(imm_op_word(OP_ST, 4'd3, 4'd0, 20'd21));
        emit(imm_op_word(OP_HLT, 4'd0, 4'd0, 20'd0));
        run_program(1'b0);

        // loop of three, taken and not-taken beq, jmp over a store
        clear_program();
        emit(imm_op_word(OP_ADDI, 4'd1, 4'd0, 20'd3));
        emit(imm_op_word(OP_ADDI, 4'd2, 4'd0, 20'd0));
        emit(imm_op_word(OP_ADDI, 4'd2, 4'd2, 20'd7));
        emit(imm_op_word(OP_ST, 4'd2, 4'd1, 20'd30));
        emit(imm_op_word(OP_ADDI, 4'd1, 4'd1, 20'hfffff));
        emit(imm_op_word(OP_BNE, 4'd1, 4'd0, 20'hffffd));
        emit(imm_op_word(OP_BEQ, 4'd1, 4'd0, 20'd2));
        emit(imm_op_word(OP_ST, 4'd2, 4'd0, 20'd40));
        emit(imm_op_word(OP_BEQ, 4'd2, 4'd0, 20'd5));
        emit(imm_op_word(OP_ST, 4'd2, 4'd0, 20'd41));
        emit(imm_op_word(OP_JMP, 4'd0, 4'd0, 20'd2));
        emit(imm_op_word(OP_ST, 4'd1, 4'd0, 20'd42));
        emit(imm_op_word(OP_ST, 4'd2, 4'd0, 20'd43));
        emit(imm_op_word(OP_HLT, 4'd0, 4'd0, 20'd0));
        run_program(1'b0);

        build_random_program();
        run_program(1'b0);
        run_program(1'b1);

        $display("RESULT: PASS");
        $finish;
    end

endmodule

`default_nettype wire

//--- project.f
src/cpu_isa_pkg.sv
src/cpu_pipe_pkg.sv
src/fetch_stage.sv
src/decode_stage.sv
src/reg_file.sv
src/execute_stage.sv
src/cpu_top.sv
test/cpu_assertions.sv
test/tb_cpu_top.sv

//--- Makefile
TOOL     ?= verilator
FLAGS    ?= --binary --timing --assert -j 0
TOP      ?= tb_cpu_top
FILELIST ?= project.f
PASS_MSG := RESULT: PASS

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with $(TOOL) and run the testbench"
	@echo "  clean  remove build output"
	@echo "  help   show this list"

test:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf obj_dir
